// File: logic/fpu_lite_macros.svh
// Data width, tag width, format count and per-format pipeline depth defines

`ifndef FPU_LITE_MACROS_SVH
`define FPU_LITE_MACROS_SVH

// ---------------------------------------------------------------------------
// Datapath sizes
// ---------------------------------------------------------------------------
`define FPU_WIDTH 32
`define FPU_TAG_W 4

// Number of parallel format slices
`define FPU_NUM_FMTS 2

// ---------------------------------------------------------------------------
// Slice latencies in cycles
// ---------------------------------------------------------------------------
`define FP32_PIPE_REGS 2
`define FP16_PIPE_REGS 1

`endif

// File: logic/fpu_lite_pkg.sv
// Format, operation and rounding-mode enums, status flags and slice output types

`include "fpu_lite_macros.svh"

package fpu_lite_pkg;

  // ---------------------------------------------------------------------------
  // Encodings
  // ---------------------------------------------------------------------------

  // Destination format, one slice each
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  // Non-computational operations
  typedef enum logic {
    MINMAX = 1'b0,
    SGNJ   = 1'b1
  } operation_e;

  // Sub-operation select
  // MINMAX uses RNE for min and RTZ for max
  // SGNJ uses RNE for sgnj, RTZ for sgnjn and RDN for sgnjx
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010
  } roundmode_e;

  // ---------------------------------------------------------------------------
  // Result side
  // ---------------------------------------------------------------------------

  // IEEE exception flags
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef logic [`FPU_TAG_W-1:0] tag_t;

  // What a slice hands to the output arbiter
  typedef struct packed {
    logic [`FPU_WIDTH-1:0] result;
    status_t               status;
    tag_t                  tag;
  } slice_out_t;

endpackage

// File: logic/noncomp_lane.sv
// Single-lane min/max and sign-injection datapath with signaling-NaN detection

`timescale 1ns/1ps

module noncomp_lane #(
  parameter int unsigned ExpBits = 8,
  parameter int unsigned ManBits = 23
) (
  input  logic [ExpBits+ManBits:0] operand_a_i,
  input  logic [ExpBits+ManBits:0] operand_b_i,
  input  fpu_lite_pkg::operation_e op_i,
  input  fpu_lite_pkg::roundmode_e rnd_mode_i,
  output logic [ExpBits+ManBits:0] result_o,
  output logic                     nv_o
);

  import fpu_lite_pkg::*;

  typedef struct packed {
    logic               sign;
    logic [ExpBits-1:0] exponent;
    logic [ManBits-1:0] mantissa;
  } fp_t;

  typedef struct packed {
    logic is_nan;
    logic is_signaling;
  } fp_class_t;

  // Positive quiet NaN with only the leading mantissa bit set
  localparam fp_t CanonNan = '{
    sign:     1'b0,
    exponent: '1,
    mantissa: {1'b1, {(ManBits-1){1'b0}}}
  };

  fp_t       op_a;
  fp_t       op_b;
  fp_class_t class_a;
  fp_class_t class_b;
  logic      a_lt_b;
  logic      sel_max;
  logic      sign_inj;

  assign op_a = operand_a_i;
  assign op_b = operand_b_i;

  // ---------------------------------------------------------------------------
  // Operand classification
  // ---------------------------------------------------------------------------
  assign class_a.is_nan       = (&op_a.exponent) & (|op_a.mantissa);
  assign class_a.is_signaling = class_a.is_nan & ~op_a.mantissa[ManBits-1];
  assign class_b.is_nan       = (&op_b.exponent) & (|op_b.mantissa);
  assign class_b.is_signaling = class_b.is_nan & ~op_b.mantissa[ManBits-1];

  // Sign-magnitude ordering, -0 sorts below +0
  always_comb begin
    if (op_a.sign != op_b.sign) begin
      a_lt_b = op_a.sign;
    end else if (op_a.sign) begin
      a_lt_b = {op_a.exponent, op_a.mantissa} > {op_b.exponent, op_b.mantissa};
    end else begin
      a_lt_b = {op_a.exponent, op_a.mantissa} < {op_b.exponent, op_b.mantissa};
    end
  end

  assign sel_max = (rnd_mode_i == RTZ);

  // Sign source for injection
  always_comb begin
    unique case (rnd_mode_i)
      RTZ:     sign_inj = ~op_b.sign;
      RDN:     sign_inj = op_a.sign ^ op_b.sign;
      default: sign_inj = op_b.sign;
    endcase
  end

  // ---------------------------------------------------------------------------
  // Result select
  // ---------------------------------------------------------------------------
  always_comb begin
    result_o = operand_a_i;
    nv_o     = 1'b0;
    unique case (op_i)
      MINMAX: begin
        nv_o = class_a.is_signaling | class_b.is_signaling;
        if (class_a.is_nan && class_b.is_nan) begin
          result_o = CanonNan;
        end else if (class_a.is_nan) begin
          result_o = operand_b_i;
        end else if (class_b.is_nan) begin
          result_o = operand_a_i;
        end else if (sel_max) begin
          result_o = a_lt_b ? operand_b_i : operand_a_i;
        end else begin
          result_o = a_lt_b ? operand_a_i : operand_b_i;
        end
      end
      SGNJ: begin
        // Magnitude always from a
        result_o = {sign_inj, op_a.exponent, op_a.mantissa};
      end
    endcase
  end

endmodule

// File: logic/fmt_slice.sv
// Format slice with SIMD lanes, NaN-box check and a flushable valid/ready pipeline

`timescale 1ns/1ps

`include "fpu_lite_macros.svh"

module fmt_slice #(
  parameter fpu_lite_pkg::fp_format_e FpFormat    = fpu_lite_pkg::FP32,
  parameter int unsigned              NumPipeRegs = 1
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [1:0][`FPU_WIDTH-1:0]  operands_i,
  input  fpu_lite_pkg::operation_e    op_i,
  input  fpu_lite_pkg::roundmode_e    rnd_mode_i,
  input  logic                        vectorial_op_i,
  input  fpu_lite_pkg::tag_t          tag_i,
  input  logic [1:0]                  simd_mask_i,
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  logic                        flush_i,
  output fpu_lite_pkg::slice_out_t    out_data_o,
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output logic                        busy_o
);

  import fpu_lite_pkg::*;

  localparam int unsigned NumLanes  = (FpFormat == FP16) ? 2 : 1;
  localparam int unsigned ExpBits   = (FpFormat == FP16) ? 5 : 8;
  localparam int unsigned ManBits   = (FpFormat == FP16) ? 10 : 23;
  localparam int unsigned LaneWidth = ExpBits + ManBits + 1;

  localparam logic [LaneWidth-1:0] CanonNan =
      {1'b0, {ExpBits{1'b1}}, 1'b1, {(ManBits-1){1'b0}}};

  // Bits of lane 0, ignored by the boxing check
  localparam logic [`FPU_WIDTH-1:0] LaneZeroBits = ~({`FPU_WIDTH{1'b1}} << LaneWidth);

  logic [NumLanes-1:0][LaneWidth-1:0] lane_result;
  logic [NumLanes-1:0]                lane_nv;
  logic [NumLanes-1:0]                lane_active;
  logic [1:0]                         op_boxed;
  logic [`FPU_WIDTH-1:0]              slice_result;
  status_t                            slice_status;

  // ---------------------------------------------------------------------------
  // Lanes
  // ---------------------------------------------------------------------------

  // Scalar narrow operands need all ones above lane 0
  for (genvar op = 0; op < 2; op++) begin : gen_box_check
    assign op_boxed[op] = &(operands_i[op] | LaneZeroBits);
  end

  for (genvar lane = 0; lane < NumLanes; lane++) begin : gen_lanes
    logic [1:0][LaneWidth-1:0] lane_ops;

    assign lane_active[lane] = (lane == 0) || vectorial_op_i;

    always_comb begin
      for (int op = 0; op < 2; op++) begin
        lane_ops[op] = operands_i[op][lane*LaneWidth +: LaneWidth];
        // Badly boxed scalar operand reads as quiet NaN
        if (lane == 0 && !vectorial_op_i && !op_boxed[op]) begin
          lane_ops[op] = CanonNan;
        end
      end
    end

    noncomp_lane #(
      .ExpBits ( ExpBits ),
      .ManBits ( ManBits )
    ) u_lane (
      .operand_a_i ( lane_ops[0]       ),
      .operand_b_i ( lane_ops[1]       ),
      .op_i        ( op_i              ),
      .rnd_mode_i  ( rnd_mode_i        ),
      .result_o    ( lane_result[lane] ),
      .nv_o        ( lane_nv[lane]     )
    );

    // Upper half of a scalar result is the NaN box
    assign slice_result[lane*LaneWidth +: LaneWidth] =
        lane_active[lane] ? lane_result[lane] : '1;
  end

  // Only active, unmasked lanes raise NV
  assign slice_status = '{
    nv:      |(lane_nv & lane_active & simd_mask_i[NumLanes-1:0]),
    default: 1'b0
  };

  // ---------------------------------------------------------------------------
  // Output pipeline
  // ---------------------------------------------------------------------------
  slice_out_t           stage_data  [NumPipeRegs+1];
  logic                 stage_valid [NumPipeRegs+1];
  logic [NumPipeRegs:0] stage_ready;

  assign stage_data[0]  = '{result: slice_result, status: slice_status, tag: tag_i};
  assign stage_valid[0] = in_valid_i;
  assign in_ready_o     = stage_ready[0];

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_pipe
    // Stage accepts when empty or when it drains this cycle
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i || flush_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[i] && stage_valid[i]) begin
        stage_data[i+1] <= stage_data[i];
      end
    end
  end

  assign stage_ready[NumPipeRegs] = out_ready_i;
  assign out_valid_o              = stage_valid[NumPipeRegs];
  assign out_data_o               = stage_data[NumPipeRegs];

  // Any stage holding an operation
  always_comb begin
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NumPipeRegs; i++) begin
      busy_o |= stage_valid[i];
    end
  end

endmodule

// File: logic/rr_arbiter.sv
// Round-robin arbiter for slice results with grant hold under back-pressure

`timescale 1ns/1ps

module rr_arbiter #(
  parameter int unsigned NumIn = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                flush_i,
  input  logic [NumIn-1:0]                    req_i,
  output logic [NumIn-1:0]                    gnt_o,
  input  fpu_lite_pkg::slice_out_t [NumIn-1:0] data_i,
  output logic                                req_o,
  input  logic                                gnt_i,
  output fpu_lite_pkg::slice_out_t            data_o
);

  import fpu_lite_pkg::*;

  localparam int unsigned IdxW = (NumIn > 1) ? $clog2(NumIn) : 1;

  logic [IdxW-1:0] rr_q;
  logic [IdxW-1:0] lock_idx_q;
  logic            lock_q;
  logic [IdxW-1:0] pick_idx;
  logic            pick_found;
  logic [IdxW-1:0] sel_idx;

  // ---------------------------------------------------------------------------
  // Winner search from the pointer onwards
  // ---------------------------------------------------------------------------
  always_comb begin
    int unsigned cand;
    pick_idx   = rr_q;
    pick_found = 1'b0;
    for (int unsigned off = 0; off < NumIn; off++) begin
      cand = (32'(rr_q) + off) % NumIn;
      if (!pick_found && req_i[cand]) begin
        pick_idx   = IdxW'(cand);
        pick_found = 1'b1;
      end
    end
  end

  // Stalled winner keeps the output
  assign sel_idx = lock_q ? lock_idx_q : pick_idx;
  assign req_o   = lock_q ? req_i[lock_idx_q] : pick_found;
  assign data_o  = data_i[sel_idx];

  always_comb begin
    gnt_o = '0;
    gnt_o[sel_idx] = req_o & gnt_i;
  end

  // ---------------------------------------------------------------------------
  // Pointer and lock state
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (flush_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= req_o & ~gnt_i;
      if (req_o && !gnt_i) begin
        lock_idx_q <= sel_idx;
      end
      // Move past the winner once it has transferred
      if (req_o && gnt_i) begin
        rr_q <= (sel_idx == IdxW'(NumIn - 1)) ? '0 : sel_idx + 1'b1;
      end
    end
  end

endmodule

// File: logic/opgroup_block.sv
// Non-computational FP operation group with FP32 and FP16 slices and output arbiter

`timescale 1ns/1ps

`include "fpu_lite_macros.svh"

module opgroup_block (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Operation
  input  logic [1:0][`FPU_WIDTH-1:0] operands_i,
  input  fpu_lite_pkg::operation_e   op_i,
  input  fpu_lite_pkg::roundmode_e   rnd_mode_i,
  input  fpu_lite_pkg::fp_format_e   dst_fmt_i,
  input  logic                       vectorial_op_i,
  input  fpu_lite_pkg::tag_t         tag_i,
  input  logic [1:0]                 simd_mask_i,
  // Input handshake
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  logic                       flush_i,
  // Result
  output logic [`FPU_WIDTH-1:0]      result_o,
  output fpu_lite_pkg::status_t      status_o,
  output fpu_lite_pkg::tag_t         tag_o,
  // Output handshake
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output logic                       busy_o
);

  import fpu_lite_pkg::*;

  localparam int unsigned NumFmts = `FPU_NUM_FMTS;

  logic [NumFmts-1:0]       fmt_in_valid;
  logic [NumFmts-1:0]       fmt_in_ready;
  logic [NumFmts-1:0]       fmt_out_valid;
  logic [NumFmts-1:0]       fmt_out_ready;
  logic [NumFmts-1:0]       fmt_busy;
  slice_out_t [NumFmts-1:0] fmt_out_data;
  slice_out_t               arb_out;

  // ---------------------------------------------------------------------------
  // Input steering
  // ---------------------------------------------------------------------------

  // Addressed slice decides acceptance
  assign in_ready_o = in_valid_i & fmt_in_ready[dst_fmt_i];

  for (genvar fmt = 0; fmt < NumFmts; fmt++) begin : gen_slices
    localparam fp_format_e SliceFmt = fp_format_e'(fmt);
    localparam int unsigned SliceRegs =
        (SliceFmt == FP16) ? `FP16_PIPE_REGS : `FP32_PIPE_REGS;

    logic [1:0] slice_mask;

    assign fmt_in_valid[fmt] = in_valid_i & (dst_fmt_i == SliceFmt);

    // FP32 has a single lane
    assign slice_mask = (SliceFmt == FP16) ? simd_mask_i : {1'b0, simd_mask_i[0]};

    fmt_slice #(
      .FpFormat    ( SliceFmt  ),
      .NumPipeRegs ( SliceRegs )
    ) u_fmt_slice (
      .clk_i          ( clk_i              ),
      .rst_n_i        ( rst_n_i            ),
      .operands_i     ( operands_i         ),
      .op_i           ( op_i               ),
      .rnd_mode_i     ( rnd_mode_i         ),
      .vectorial_op_i ( vectorial_op_i     ),
      .tag_i          ( tag_i              ),
      .simd_mask_i    ( slice_mask         ),
      .in_valid_i     ( fmt_in_valid[fmt]  ),
      .in_ready_o     ( fmt_in_ready[fmt]  ),
      .flush_i        ( flush_i            ),
      .out_data_o     ( fmt_out_data[fmt]  ),
      .out_valid_o    ( fmt_out_valid[fmt] ),
      .out_ready_i    ( fmt_out_ready[fmt] ),
      .busy_o         ( fmt_busy[fmt]      )
    );
  end

  // ---------------------------------------------------------------------------
  // Output merge
  // ---------------------------------------------------------------------------
  rr_arbiter #(
    .NumIn ( NumFmts )
  ) u_arbiter (
    .clk_i   ( clk_i         ),
    .rst_n_i ( rst_n_i       ),
    .flush_i ( flush_i       ),
    .req_i   ( fmt_out_valid ),
    .gnt_o   ( fmt_out_ready ),
    .data_i  ( fmt_out_data  ),
    .req_o   ( out_valid_o   ),
    .gnt_i   ( out_ready_i   ),
    .data_o  ( arb_out       )
  );

  assign result_o = arb_out.result;
  assign status_o = arb_out.status;
  assign tag_o    = arb_out.tag;

  assign busy_o = |fmt_busy;

endmodule

// File: tb/noncomp_model.svh
// Reference model functions for min/max and sign injection in FP32 and FP16

`ifndef NONCOMP_MODEL_SVH
`define NONCOMP_MODEL_SVH

// One lane of eb exponent bits and mb mantissa bits, held in the low bits
function automatic logic [31:0] lane_ref(input logic [31:0] a, input logic [31:0] b,
                                         input int eb, input int mb, input logic is_sgnj,
                                         input logic [2:0] rm, output logic nv);
  logic [63:0] all_ones;
  logic [63:0] mag_mask;
  logic [63:0] mag_a;
  logic [63:0] mag_b;
  logic [63:0] canon;
  logic        a_nan;
  logic        b_nan;
  logic        sa;
  logic        sb;
  logic        sign;
  logic        a_less;
  int          w;
  w        = eb + mb + 1;
  all_ones = (64'd1 << eb) - 1;
  mag_mask = (64'd1 << (w - 1)) - 1;
  mag_a    = a & mag_mask;
  mag_b    = b & mag_mask;
  sa       = a[w-1];
  sb       = b[w-1];
  a_nan    = ((mag_a >> mb) == all_ones) && ((mag_a & ((64'd1 << mb) - 1)) != 0);
  b_nan    = ((mag_b >> mb) == all_ones) && ((mag_b & ((64'd1 << mb) - 1)) != 0);
  canon    = (all_ones << mb) | (64'd1 << (mb - 1));
  if (is_sgnj) begin
    nv = 1'b0;
    case (rm)
      3'd1:    sign = ~sb;
      3'd2:    sign = sa ^ sb;
      default: sign = sb;
    endcase
    return 32'(mag_a | (64'(sign) << (w - 1)));
  end
  // Signaling NaN has the quiet bit clear
  nv = (a_nan && !a[mb-1]) || (b_nan && !b[mb-1]);
  if (a_nan && b_nan) begin
    return 32'(canon);
  end
  if (a_nan) begin
    return b;
  end
  if (b_nan) begin
    return a;
  end
  if (sa != sb) begin
    a_less = sa;
  end else if (sa) begin
    a_less = mag_a > mag_b;
  end else begin
    a_less = mag_a < mag_b;
  end
  // rm of 1 selects max
  if (rm == 3'd1) begin
    return a_less ? b : a;
  end
  return a_less ? a : b;
endfunction

// Whole operation as seen at the block output, status packed as nv,dz,of,uf,nx
function automatic void expected_op(input logic [31:0] a, input logic [31:0] b,
                                    input logic is_sgnj, input logic [2:0] rm,
                                    input logic fmt, input logic vec, input logic [1:0] mask,
                                    output logic [31:0] res, output logic [4:0] status);
  logic [31:0] r0;
  logic [31:0] r1;
  logic [31:0] a0;
  logic [31:0] b0;
  logic        nv0;
  logic        nv1;
  if (!fmt) begin
    res    = lane_ref(a, b, 8, 23, is_sgnj, rm, nv0);
    status = {nv0 & mask[0], 4'b0};
  end else if (vec) begin
    r0     = lane_ref({16'h0, a[15:0]}, {16'h0, b[15:0]}, 5, 10, is_sgnj, rm, nv0);
    r1     = lane_ref({16'h0, a[31:16]}, {16'h0, b[31:16]}, 5, 10, is_sgnj, rm, nv1);
    res    = {r1[15:0], r0[15:0]};
    status = {(nv0 & mask[0]) | (nv1 & mask[1]), 4'b0};
  end else begin
    // Improperly boxed scalar input reads as the canonical NaN
    a0     = (a[31:16] == 16'hffff) ? {16'h0, a[15:0]} : 32'h7e00;
    b0     = (b[31:16] == 16'hffff) ? {16'h0, b[15:0]} : 32'h7e00;
    r0     = lane_ref(a0, b0, 5, 10, is_sgnj, rm, nv0);
    res    = {16'hffff, r0[15:0]};
    status = {nv0 & mask[0], 4'b0};
  end
endfunction

`endif

// File: tb/tb_opgroup_block.sv
// Testbench for opgroup_block with random stimulus, tag scoreboard and flush checks

`timescale 1ns/1ps

`include "fpu_lite_macros.svh"

module tb_opgroup_block;

  import fpu_lite_pkg::*;

  logic                       clk_i;
  logic                       rst_n_i;
  logic [1:0][`FPU_WIDTH-1:0] operands_i;
  operation_e                 op_i;
  roundmode_e                 rnd_mode_i;
  fp_format_e                 dst_fmt_i;
  logic                       vectorial_op_i;
  tag_t                       tag_i;
  logic [1:0]                 simd_mask_i;
  logic                       in_valid_i;
  logic                       in_ready_o;
  logic                       flush_i;
  logic [`FPU_WIDTH-1:0]      result_o;
  status_t                    status_o;
  tag_t                       tag_o;
  logic                       out_valid_o;
  logic                       out_ready_i;
  logic                       busy_o;

  // Scoreboard indexed by tag
  logic        pending  [16];
  logic [31:0] exp_res  [16];
  logic [4:0]  exp_stat [16];
  logic        exp_fmt  [16];
  logic [3:0]  q_fp32[$];
  logic [3:0]  q_fp16[$];

  int          errors;
  int          checks;
  int          received;
  int          test_err;
  logic [31:0] rng_state;
  logic [31:0] bp_state;
  logic        bp_mode;
  logic [3:0]  next_tag;

  `include "noncomp_model.svh"

  opgroup_block UUT (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .operands_i     ( operands_i     ),
    .op_i           ( op_i           ),
    .rnd_mode_i     ( rnd_mode_i     ),
    .dst_fmt_i      ( dst_fmt_i      ),
    .vectorial_op_i ( vectorial_op_i ),
    .tag_i          ( tag_i          ),
    .simd_mask_i    ( simd_mask_i    ),
    .in_valid_i     ( in_valid_i     ),
    .in_ready_o     ( in_ready_o     ),
    .flush_i        ( flush_i        ),
    .result_o       ( result_o       ),
    .status_o       ( status_o       ),
    .tag_o          ( tag_o          ),
    .out_valid_o    ( out_valid_o    ),
    .out_ready_i    ( out_ready_i    ),
    .busy_o         ( busy_o         )
  );

  always #4 clk_i = ~clk_i;

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expd);
    checks++;
    if (got !== expd) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expd);
      errors++;
    end
  endtask

  // Random bits mixed with NaNs, zeros and infinities
  function automatic logic [31:0] pick_fp32();
    logic [31:0] r;
    r = rand32();
    case (r[31:29])
      3'd0:    return {r[0], 8'hff, 1'b1, r[22:1]};
      3'd1:    return {r[0], 8'hff, 1'b0, r[22:2], 1'b1};
      3'd2:    return {r[0], 31'h0};
      3'd3:    return {r[0], 8'hff, 23'h0};
      default: return rand32();
    endcase
  endfunction

  function automatic logic [15:0] pick_fp16();
    logic [31:0] r;
    r = rand32();
    case (r[31:29])
      3'd0:    return {r[0], 5'h1f, 1'b1, r[9:1]};
      3'd1:    return {r[0], 5'h1f, 1'b0, r[9:2], 1'b1};
      3'd2:    return {r[0], 15'h0};
      default: return r[15:0];
    endcase
  endfunction

  task automatic send_op(input logic [31:0] a, input logic [31:0] b, input logic sg,
                         input logic [2:0] rm, input logic fmt, input logic vec,
                         input logic [1:0] mask);
    logic [3:0]  t;
    logic [31:0] er;
    logic [4:0]  es;
    int          waited;
    logic        done;
    t = next_tag;
    for (int i = 0; i < 16 && pending[t]; i++) begin
      t = t + 4'd1;
    end
    next_tag = t + 4'd1;
    @(posedge clk_i);
    operands_i     <= {b, a};
    op_i           <= operation_e'(sg);
    rnd_mode_i     <= roundmode_e'(rm);
    dst_fmt_i      <= fp_format_e'(fmt);
    vectorial_op_i <= vec;
    simd_mask_i    <= mask;
    tag_i          <= t;
    in_valid_i     <= 1'b1;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < 200) begin
      @(negedge clk_i);
      if (in_ready_o) begin
        done = 1'b1;
      end else begin
        waited++;
      end
    end
    if (!done) begin
      $display("error at %0t: operation with tag %0d was never accepted", $time, t);
      errors++;
      @(posedge clk_i);
      in_valid_i <= 1'b0;
    end else begin
      // Transfer completes at the coming rising edge
      expected_op(a, b, sg, rm, fmt, vec, mask, er, es);
      pending[t]  = 1'b1;
      exp_res[t]  = er;
      exp_stat[t] = es;
      exp_fmt[t]  = fmt;
      if (fmt) begin
        q_fp16.push_back(t);
      end else begin
        q_fp32.push_back(t);
      end
    end
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  task automatic random_op(input logic fmt);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic        vec;
    r   = rand32();
    vec = r[4];
    if (!fmt) begin
      a = pick_fp32();
      b = pick_fp32();
    end else if (vec) begin
      a = {pick_fp16(), pick_fp16()};
      b = {pick_fp16(), pick_fp16()};
    end else begin
      // Roughly one operand in four badly boxed
      a = {(r[6:5] == 2'b00) ? r[31:16] & 16'h7fff : 16'hffff, pick_fp16()};
      b = {(r[8:7] == 2'b00) ? r[30:15] & 16'hbfff : 16'hffff, pick_fp16()};
    end
    send_op(a, b, r[0], r[0] ? 3'(r[3:1] % 3) : {2'b0, r[1]}, fmt, vec,
            (r[10:9] == 2'b00) ? r[12:11] : 2'b11);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((q_fp32.size() != 0 || q_fp16.size() != 0) && waited < 500) begin
      @(negedge clk_i);
      waited++;
    end
    if (waited >= 500) begin
      $display("error at %0t: outstanding operations did not drain", $time);
      errors++;
    end
    // Last transfer empties its stage at the following edge
    @(negedge clk_i);
    check_value("busy_o", busy_o, 1'b0);
  endtask

  task automatic end_test(input string name);
    $display("test %s: %s (%0d errors)", name, (errors == test_err) ? "ok" : "failed",
             errors - test_err);
    test_err = errors;
  endtask

  // ---------------------------------------------------------------------------
  // Output monitor and back-pressure
  // ---------------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_n_i && out_valid_o && out_ready_i) begin
      if (!pending[tag_o]) begin
        $display("error at %0t: result with tag %0d that is not in flight", $time, tag_o);
        errors++;
      end else begin
        check_value("result_o", result_o, exp_res[tag_o]);
        check_value("status_o", status_o, exp_stat[tag_o]);
        if (exp_fmt[tag_o]) begin
          check_value("tag_o order fp16", tag_o, q_fp16[0]);
          void'(q_fp16.pop_front());
        end else begin
          check_value("tag_o order fp32", tag_o, q_fp32[0]);
          void'(q_fp32.pop_front());
        end
        pending[tag_o] = 1'b0;
        received++;
      end
    end
  end

  always @(posedge clk_i) begin
    if (bp_mode) begin
      bp_state = xorshift32(bp_state);
      out_ready_i <= bp_state[7];
    end
  end

  // ---------------------------------------------------------------------------
  // Tests
  // ---------------------------------------------------------------------------
  initial begin
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    operands_i     = '0;
    op_i           = MINMAX;
    rnd_mode_i     = RNE;
    dst_fmt_i      = FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    simd_mask_i    = 2'b11;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    out_ready_i    = 1'b1;
    bp_mode        = 1'b0;
    errors         = 0;
    checks         = 0;
    received       = 0;
    test_err       = 0;
    next_tag       = '0;
    rng_state      = 32'd75;
    bp_state       = xorshift32(32'd75);
    for (int i = 0; i < 16; i++) begin
      pending[i] = 1'b0;
    end
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;

    @(negedge clk_i);
    check_value("out_valid_o", out_valid_o, 1'b0);
    check_value("busy_o", busy_o, 1'b0);
    check_value("in_ready_o", in_ready_o, 1'b0);
    end_test("reset state");

    send_op(32'h7f800001, 32'h3f800000, 1'b0, 3'd0, 1'b0, 1'b0, 2'b11);
    send_op(32'h80000000, 32'h00000000, 1'b0, 3'd0, 1'b0, 1'b0, 2'b11);
    send_op(32'h80000000, 32'h00000000, 1'b0, 3'd1, 1'b0, 1'b0, 2'b11);
    send_op(32'h7fc00000, 32'h7f800001, 1'b0, 3'd1, 1'b0, 1'b0, 2'b11);
    for (int i = 0; i < 60; i++) begin
      random_op(1'b0);
    end
    go_idle();
    wait_drain();
    end_test("fp32 minmax and sgnj");

    // Vector, scalar, bad box, masked signaling lane
    send_op(32'h3c00c000, 32'hbc004000, 1'b0, 3'd0, 1'b1, 1'b1, 2'b11);
    send_op(32'hffff3c00, 32'hffffc000, 1'b1, 3'd2, 1'b1, 1'b0, 2'b11);
    send_op(32'h12343c00, 32'hffffc000, 1'b0, 3'd1, 1'b1, 1'b0, 2'b11);
    send_op(32'h7d013c00, 32'h3c003c00, 1'b0, 3'd0, 1'b1, 1'b1, 2'b01);
    send_op(32'h7d013c00, 32'h3c003c00, 1'b0, 3'd0, 1'b1, 1'b1, 2'b10);
    for (int i = 0; i < 40; i++) begin
      random_op(1'b1);
    end
    go_idle();
    wait_drain();
    end_test("fp16 lanes, boxing and mask");

    bp_mode = 1'b1;
    for (int i = 0; i < 120; i++) begin
      random_op(1'(rand32() >> 31));
    end
    go_idle();
    wait_drain();
    bp_mode = 1'b0;
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    end_test("mixed formats with back-pressure");

    @(posedge clk_i);
    out_ready_i <= 1'b0;
    send_op(32'h3f800000, 32'h40000000, 1'b0, 3'd0, 1'b0, 1'b0, 2'b11);
    send_op(32'h3f800000, 32'hc0000000, 1'b1, 3'd1, 1'b0, 1'b0, 2'b11);
    send_op(32'h3c003c00, 32'h40004000, 1'b0, 3'd1, 1'b1, 1'b1, 2'b11);
    go_idle();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    // Flushed operations leave the scoreboard
    for (int i = 0; i < 16; i++) begin
      pending[i] = 1'b0;
    end
    q_fp32.delete();
    q_fp16.delete();
    out_ready_i <= 1'b1;
    @(negedge clk_i);
    check_value("busy_o", busy_o, 1'b0);
    check_value("out_valid_o", out_valid_o, 1'b0);
    for (int i = 0; i < 10; i++) begin
      random_op(i[0]);
    end
    go_idle();
    wait_drain();
    end_test("flush");

    $display("checks %0d, results %0d, errors %0d", checks, received, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+logic
+incdir+tb
logic/fpu_lite_pkg.sv
logic/noncomp_lane.sv
logic/fmt_slice.sv
logic/rr_arbiter.sv
logic/opgroup_block.sv
tb/tb_opgroup_block.sv

// File: Bender.yml
package:
  name: opgroup_block

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/fpu_lite_pkg.sv
      - logic/noncomp_lane.sv
      - logic/fmt_slice.sv
      - logic/rr_arbiter.sv
      - logic/opgroup_block.sv
  - target: test
    include_dirs:
      - logic
      - tb
    files:
      - tb/tb_opgroup_block.sv
